// ==== build.f ====
+incdir+rtl
rtl/dbg_data_pkg.sv
rtl/dbg_ctrl_pkg.sv
rtl/instr_assembler.sv
rtl/command_fsm.sv
rtl/response_fifo.sv
rtl/response_transmitter.sv
rtl/debugger_control.sv
testbench/tb_debugger_control.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_debugger_control -f build.f
	./obj_dir/Vtb_debugger_control | tee sim.log
	grep -q "all tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== testbench/tb_debugger_control.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dbg_cfg.svh"

module tb_debugger_control
    import dbg_data_pkg::*;
    import dbg_ctrl_pkg::*;
();

    localparam int END_DELAY = 15;

    logic        i_clk;
    logic        i_reset;
    logic        i_rd_end;
    uart_byte_t  i_rd_data;
    logic        o_rd_start;
    logic        o_wr_start;
    resp_word_t  o_wr_data;
    logic        i_wr_end;
    logic        i_imem_full;
    logic        i_cpu_end_program;
    logic        o_cpu_flush;
    logic        o_cpu_clear_program;
    logic        o_cpu_enable;
    imem_write_t o_imem;

    integer      seed = 86;
    uart_byte_t  rx_queue[$];
    resp_word_t  expect_words[$];
    instr_t      expect_instrs[$];
    logic        expect_halts[$];
    string       test_name = "reset";
    int          mismatches = 0;
    int          failures = 0;
    int          cycle = 0;
    int          bytes_total = 0;
    int          msgs_total = 0;
    int          tx_min = 1;
    int          tx_max = 4;
    int          words_seen = 0;
    int          flush_count = 0;
    int          clear_count = 0;
    int          enable_cycles = 0;
    int          imem_count = 0;
    logic        wr_busy = 1'b0;
    logic        prev_flush = 1'b0;
    logic        prev_clear = 1'b0;
    logic        prev_enable = 1'b0;
    logic        prev_end = 1'b0;
    logic        prev_rd_end = 1'b0;

    debugger_control UUT (
        .i_clk               (i_clk),
        .i_reset             (i_reset),
        .i_rd_end            (i_rd_end),
        .i_rd_data           (i_rd_data),
        .o_rd_start          (o_rd_start),
        .o_wr_start          (o_wr_start),
        .o_wr_data           (o_wr_data),
        .i_wr_end            (i_wr_end),
        .i_imem_full         (i_imem_full),
        .i_cpu_end_program   (i_cpu_end_program),
        .o_cpu_flush         (o_cpu_flush),
        .o_cpu_clear_program (o_cpu_clear_program),
        .o_cpu_enable        (o_cpu_enable),
        .o_imem              (o_imem)
    );

    // prefix on top, 16 zero bits, code at the bottom
    function automatic resp_word_t response_word(input uart_byte_t prefix, input msg_code_t code);
        return {prefix, 16'h0000, code};
    endfunction

    task automatic compare_value(input string what, input logic [31:0] expected,
                                 input logic [31:0] actual);
        assert (actual === expected)
        else
        begin
            mismatches++;
            $display("Mismatch in %s (%s): expected %h, actual %h",
                     test_name, what, expected, actual);
        end
    endtask

    task automatic report_failure(input string text);
        failures++;
        $display("%s: %s", test_name, text);
    endtask

    task automatic send_byte(input uart_byte_t b);
        rx_queue.push_back(b);
        bytes_total++;
    endtask

    task automatic expect_response(input uart_byte_t prefix, input msg_code_t code);
        expect_words.push_back(response_word(prefix, code));
        msgs_total++;
    endtask

    // first byte on the wire is the most significant one
    task automatic load_word(input instr_t instr, input logic halt);
        expect_instrs.push_back(instr);
        expect_halts.push_back(halt);
        send_byte(instr[31:24]);
        send_byte(instr[23:16]);
        send_byte(instr[15:8]);
        send_byte(instr[7:0]);
    endtask

    // done once the FSM asks for a byte that is not there and all words are out
    task automatic wait_until_idle();
        logic requested;
        requested = 1'b0;
        while (!(requested && rx_queue.size() == 0 && expect_words.size() == 0 && !wr_busy))
        begin
            @(negedge i_clk);
            if (o_rd_start && rx_queue.size() == 0)
            begin
                requested = 1'b1;
            end
        end
    endtask

    initial
    begin
        i_clk = 1'b0;
        forever #20 i_clk = ~i_clk;
    end

    // uart receiver
    initial
    begin : rx_model
        int delay;
        i_rd_end  = 1'b0;
        i_rd_data = '0;
        forever
        begin
            @(negedge i_clk);
            if (o_rd_start)
            begin
                while (rx_queue.size() == 0)
                begin
                    @(negedge i_clk);
                end
                delay = 1 + $unsigned($random(seed)) % 6;
                repeat (delay) @(posedge i_clk);
                i_rd_end  <= 1'b1;
                i_rd_data <= rx_queue.pop_front();
                @(posedge i_clk);
                i_rd_end <= 1'b0;
            end
        end
    end

    // uart transmitter with scoreboard
    initial
    begin : tx_model
        int         delay;
        resp_word_t held;
        i_wr_end = 1'b0;
        forever
        begin
            @(negedge i_clk);
            if (o_wr_start)
            begin
                wr_busy = 1'b1;
                held    = o_wr_data;
                words_seen++;
                if (expect_words.size() == 0)
                begin
                    report_failure($sformatf("unexpected response word %h", held));
                end
                else
                begin
                    compare_value("response word", expect_words.pop_front(), held);
                end
                delay = tx_min + $unsigned($random(seed)) % (tx_max - tx_min + 1);
                repeat (delay)
                begin
                    @(negedge i_clk);
                    assert (o_wr_data === held)
                    else report_failure("o_wr_data changed while a word was outstanding");
                end
                @(posedge i_clk);
                i_wr_end <= 1'b1;
                @(posedge i_clk);
                i_wr_end <= 1'b0;
                wr_busy = 1'b0;
            end
        end
    end

    // core ends its program a fixed time after enable
    initial
    begin : core_model
        i_cpu_end_program = 1'b0;
        forever
        begin
            @(negedge i_clk);
            if (o_cpu_enable)
            begin
                repeat (END_DELAY) @(posedge i_clk);
                i_cpu_end_program <= 1'b1;
                while (o_cpu_enable)
                begin
                    @(negedge i_clk);
                end
                @(posedge i_clk);
                i_cpu_end_program <= 1'b0;
            end
        end
    end

    always @(negedge i_clk)
    begin
        cycle++;
        if (!i_reset)
        begin
            if (o_cpu_flush)
            begin
                flush_count++;
            end
            if (o_cpu_clear_program)
            begin
                clear_count++;
                assert (o_cpu_flush)
                else report_failure("o_cpu_clear_program pulsed without o_cpu_flush");
            end
            if (o_cpu_enable)
            begin
                enable_cycles++;
            end
            if (prev_flush && !prev_clear)
            begin
                assert (o_cpu_enable)
                else report_failure("o_cpu_enable did not rise after the run flush");
            end
            if (prev_enable && prev_end)
            begin
                assert (!o_cpu_enable)
                else report_failure("o_cpu_enable stayed high after the end of program");
            end
            else if (prev_enable)
            begin
                assert (o_cpu_enable)
                else report_failure("o_cpu_enable fell before the end of program");
            end
            if (o_imem.strobe)
            begin
                imem_count++;
                assert (prev_rd_end)
                else report_failure("imem strobe not one cycle after a received byte");
                if (expect_instrs.size() == 0)
                begin
                    report_failure("unexpected imem write");
                end
                else
                begin
                    compare_value("imem word", expect_instrs.pop_front(), o_imem.instr);
                    compare_value("imem halt", expect_halts.pop_front(), o_imem.halt);
                end
            end
        end
        prev_flush  = o_cpu_flush;
        prev_clear  = o_cpu_clear_program;
        prev_enable = o_cpu_enable;
        prev_end    = i_cpu_end_program;
        prev_rd_end = i_rd_end;
    end

    initial
    begin : watchdog
        @(negedge i_clk);
        while (cycle <= bytes_total * 12 + msgs_total * 40 + 500)
        begin
            @(negedge i_clk);
        end
        $display("timeout: the run did not finish within %0d cycles", cycle);
        $display("tests failed");
        $finish;
    end

    initial
    begin : stimulus
        int fc;
        int cc;
        int ec;
        int ic;
        int ws;
        i_reset     = 1'b1;
        i_imem_full = 1'b0;
        repeat (2) @(posedge i_clk);
        @(posedge i_clk);
        i_reset <= 1'b0;
        @(negedge i_clk);
        assert (!o_rd_start && !o_wr_start && !o_cpu_flush && !o_cpu_clear_program
                && !o_cpu_enable && !o_imem.strobe)
        else report_failure("a control output is high after reset");

        test_name = "unknown_cmd";
        fc = flush_count;
        expect_response(`DBG_PREFIX_ERROR, `DBG_ERR_UNKNOWN_CMD);
        send_byte(8'h58);
        wait_until_idle();
        compare_value("flush pulses", fc, flush_count);

        test_name = "flush";
        fc = flush_count;
        cc = clear_count;
        ws = words_seen;
        send_byte(`DBG_CMD_FLUSH);
        wait_until_idle();
        compare_value("flush pulses", fc + 1, flush_count);
        compare_value("clear pulses", cc + 1, clear_count);
        compare_value("response words", ws, words_seen);

        test_name = "load";
        fc = flush_count;
        cc = clear_count;
        ic = imem_count;
        send_byte(`DBG_CMD_LOAD);
        load_word(32'h1234_5678, 1'b0);
        load_word(32'hA5C3_0F96, 1'b0);
        load_word(`DBG_INSTR_HALT, 1'b1);
        expect_response(`DBG_PREFIX_INFO, `DBG_INFO_LOAD_DONE);
        wait_until_idle();
        compare_value("imem writes", ic + 3, imem_count);
        compare_value("flush pulses", fc + 1, flush_count);
        compare_value("clear pulses", cc + 1, clear_count);

        test_name = "imem_full";
        ic = imem_count;
        @(posedge i_clk);
        i_imem_full <= 1'b1;
        expect_response(`DBG_PREFIX_ERROR, `DBG_ERR_IMEM_FULL);
        send_byte(`DBG_CMD_LOAD);
        wait_until_idle();
        compare_value("imem writes", ic, imem_count);
        @(posedge i_clk);
        i_imem_full <= 1'b0;

        test_name = "run";
        fc = flush_count;
        cc = clear_count;
        ec = enable_cycles;
        expect_response(`DBG_PREFIX_INFO, `DBG_INFO_END_PROGRAM);
        send_byte(`DBG_CMD_RUN);
        wait_until_idle();
        compare_value("flush pulses", fc + 1, flush_count);
        compare_value("clear pulses", cc, clear_count);
        // enable covers the delay plus the cycle in which end is seen
        compare_value("enable cycles", ec + END_DELAY + 1, enable_cycles);

        test_name = "back_pressure";
        ws     = words_seen;
        tx_min = 20;
        tx_max = 30;
        for (int i = 0; i < 6; i++)
        begin
            expect_response(`DBG_PREFIX_ERROR, `DBG_ERR_UNKNOWN_CMD);
            send_byte(8'h30 + 8'(i));
        end
        wait_until_idle();
        compare_value("response words", ws + 6, words_seen);
        tx_min = 1;
        tx_max = 4;

        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0)
        begin
            $display("all tests passed");
        end
        else
        begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== rtl/debugger_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module debugger_control
    import dbg_data_pkg::*;
    import dbg_ctrl_pkg::*;
(
    input  wire logic        i_clk,
    input  wire logic        i_reset,
    input  wire logic        i_rd_end,
    input  wire uart_byte_t  i_rd_data,
    output logic             o_rd_start,
    output logic             o_wr_start,
    output resp_word_t       o_wr_data,
    input  wire logic        i_wr_end,
    input  wire logic        i_imem_full,
    input  wire logic        i_cpu_end_program,
    output logic             o_cpu_flush,
    output logic             o_cpu_clear_program,
    output logic             o_cpu_enable,
    output imem_write_t      o_imem
);

    logic        byte_strobe;
    uart_byte_t  asm_byte;
    logic        asm_clear;
    imem_write_t imem;
    logic        push_valid;
    resp_msg_t   push_msg;
    logic        push_ready;
    logic        pop_valid;
    resp_msg_t   pop_msg;
    logic        pop;

    command_fsm u_command_fsm (
        .i_clk               (i_clk),
        .i_reset             (i_reset),
        .i_rd_end            (i_rd_end),
        .i_rd_data           (i_rd_data),
        .o_rd_start          (o_rd_start),
        .o_byte_strobe       (byte_strobe),
        .o_byte              (asm_byte),
        .o_asm_clear         (asm_clear),
        .i_imem              (imem),
        .i_imem_full         (i_imem_full),
        .i_cpu_end_program   (i_cpu_end_program),
        .o_cpu_flush         (o_cpu_flush),
        .o_cpu_clear_program (o_cpu_clear_program),
        .o_cpu_enable        (o_cpu_enable),
        .o_msg_valid         (push_valid),
        .o_msg               (push_msg),
        .i_msg_ready         (push_ready)
    );

    instr_assembler u_instr_assembler (
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .i_clear       (asm_clear),
        .i_byte_strobe (byte_strobe),
        .i_byte        (asm_byte),
        .o_imem        (imem)
    );

    response_fifo u_response_fifo (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_push_valid (push_valid),
        .i_push_msg   (push_msg),
        .o_push_ready (push_ready),
        .o_pop_valid  (pop_valid),
        .o_pop_msg    (pop_msg),
        .i_pop        (pop)
    );

    response_transmitter u_response_transmitter (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_msg_valid (pop_valid),
        .i_msg       (pop_msg),
        .o_msg_pop   (pop),
        .o_wr_start  (o_wr_start),
        .o_wr_data   (o_wr_data),
        .i_wr_end    (i_wr_end)
    );

    // the FSM and the core both see the assembled word
    assign o_imem = imem;

endmodule

`default_nettype wire

// ==== rtl/response_transmitter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dbg_cfg.svh"

module response_transmitter
    import dbg_data_pkg::*;
    import dbg_ctrl_pkg::*;
(
    input  wire logic      i_clk,
    input  wire logic      i_reset,
    input  wire logic      i_msg_valid,
    input  wire resp_msg_t i_msg,
    output logic           o_msg_pop,
    output logic           o_wr_start,
    output resp_word_t     o_wr_data,
    input  wire logic      i_wr_end
);

    localparam int PAD_BITS = `DBG_RESP_BITS - 2 * `DBG_BYTE_BITS;

    logic                     busy;
    logic                     wr_start;
    resp_word_t               wr_data;
    logic [`DBG_BYTE_BITS-1:0] prefix;

    assign o_msg_pop = !busy && i_msg_valid;
    assign prefix    = (i_msg.kind == MSG_ERROR) ? `DBG_PREFIX_ERROR : `DBG_PREFIX_INFO;

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            busy     <= 1'b0;
            wr_start <= 1'b0;
        end
        else
        begin
            wr_start <= o_msg_pop;
            if (o_msg_pop)
            begin
                busy <= 1'b1;
            end
            else if (i_wr_end)
            begin
                busy <= 1'b0;
            end
        end
    end

    // word stays put until the uart writer is done
    always_ff @(posedge i_clk)
    begin
        if (o_msg_pop)
        begin
            wr_data <= {prefix, {PAD_BITS{1'b0}}, i_msg.code};
        end
    end

    assign o_wr_start = wr_start;
    assign o_wr_data  = wr_data;

endmodule

`default_nettype wire

// ==== rtl/response_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dbg_cfg.svh"

module response_fifo
    import dbg_ctrl_pkg::*;
(
    input  wire logic      i_clk,
    input  wire logic      i_reset,
    input  wire logic      i_push_valid,
    input  wire resp_msg_t i_push_msg,
    output logic           o_push_ready,
    output logic           o_pop_valid,
    output resp_msg_t      o_pop_msg,
    input  wire logic      i_pop
);

    localparam int DEPTH    = `DBG_FIFO_DEPTH;
    localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_BITS = $clog2(DEPTH + 1);

    resp_msg_t           mem [DEPTH];
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [CNT_BITS-1:0] count;
    logic                push;
    logic                pop;

    function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] ptr);
        return (ptr == PTR_BITS'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign o_push_ready = (count != CNT_BITS'(DEPTH));
    assign o_pop_valid  = (count != '0);
    assign o_pop_msg    = mem[rd_ptr];
    assign push         = i_push_valid && o_push_ready;
    assign pop          = i_pop && o_pop_valid;

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
            begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop)
            begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (push)
        begin
            mem[wr_ptr] <= i_push_msg;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/command_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dbg_cfg.svh"

module command_fsm
    import dbg_data_pkg::*;
    import dbg_ctrl_pkg::*;
(
    input  wire logic        i_clk,
    input  wire logic        i_reset,
    input  wire logic        i_rd_end,
    input  wire uart_byte_t  i_rd_data,
    output logic             o_rd_start,
    output logic             o_byte_strobe,
    output uart_byte_t       o_byte,
    output logic             o_asm_clear,
    input  wire imem_write_t i_imem,
    input  wire logic        i_imem_full,
    input  wire logic        i_cpu_end_program,
    output logic             o_cpu_flush,
    output logic             o_cpu_clear_program,
    output logic             o_cpu_enable,
    output logic             o_msg_valid,
    output resp_msg_t        o_msg,
    input  wire logic        i_msg_ready
);

    ctrl_state_t state, state_next;
    logic        rd_start, rd_start_next;
    logic        cpu_flush, cpu_flush_next;
    logic        cpu_clear, cpu_clear_next;
    logic        cpu_enable, cpu_enable_next;
    logic        asm_clear, asm_clear_next;
    logic        msg_valid, msg_valid_next;
    resp_msg_t   msg, msg_next;

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            state      <= ST_IDLE;
            rd_start   <= 1'b0;
            cpu_flush  <= 1'b0;
            cpu_clear  <= 1'b0;
            cpu_enable <= 1'b0;
            asm_clear  <= 1'b0;
            msg_valid  <= 1'b0;
        end
        else
        begin
            state      <= state_next;
            rd_start   <= rd_start_next;
            cpu_flush  <= cpu_flush_next;
            cpu_clear  <= cpu_clear_next;
            cpu_enable <= cpu_enable_next;
            asm_clear  <= asm_clear_next;
            msg_valid  <= msg_valid_next;
        end
    end

    always_ff @(posedge i_clk)
    begin
        msg <= msg_next;
    end

    always_comb
    begin
        state_next      = state;
        rd_start_next   = 1'b0;
        cpu_flush_next  = 1'b0;
        cpu_clear_next  = 1'b0;
        asm_clear_next  = 1'b0;
        cpu_enable_next = cpu_enable;
        msg_valid_next  = msg_valid;
        msg_next        = msg;

        case (state)
            ST_IDLE:
            begin
                rd_start_next = 1'b1;
                state_next    = ST_WAIT_CMD;
            end

            ST_WAIT_CMD:
            begin
                if (i_rd_end)
                begin
                    case (i_rd_data)
                        `DBG_CMD_LOAD:
                        begin
                            cpu_flush_next = 1'b1;
                            cpu_clear_next = 1'b1;
                            asm_clear_next = 1'b1;
                            state_next     = ST_LOAD_FLUSH;
                        end
                        `DBG_CMD_FLUSH:
                        begin
                            cpu_flush_next = 1'b1;
                            cpu_clear_next = 1'b1;
                            state_next     = ST_IDLE;
                        end
                        `DBG_CMD_RUN:
                        begin
                            cpu_flush_next = 1'b1;
                            state_next     = ST_RUN;
                        end
                        default:
                        begin
                            msg_next       = '{kind: MSG_ERROR, code: `DBG_ERR_UNKNOWN_CMD};
                            msg_valid_next = 1'b1;
                            state_next     = ST_QUEUE;
                        end
                    endcase
                end
            end

            // lets the core finish clearing before full is sampled
            ST_LOAD_FLUSH:
            begin
                state_next = ST_LOAD_CHECK;
            end

            ST_LOAD_CHECK:
            begin
                if (i_imem_full)
                begin
                    msg_next       = '{kind: MSG_ERROR, code: `DBG_ERR_IMEM_FULL};
                    msg_valid_next = 1'b1;
                    state_next     = ST_QUEUE;
                end
                else
                begin
                    rd_start_next = 1'b1;
                    state_next    = ST_LOAD_BYTE;
                end
            end

            ST_LOAD_BYTE:
            begin
                if (i_rd_end)
                begin
                    state_next = ST_LOAD_WAIT;
                end
            end

            // assembler answers one cycle after the byte
            ST_LOAD_WAIT:
            begin
                if (i_imem.strobe && i_imem.halt)
                begin
                    msg_next       = '{kind: MSG_INFO, code: `DBG_INFO_LOAD_DONE};
                    msg_valid_next = 1'b1;
                    state_next     = ST_QUEUE;
                end
                else if (i_imem.strobe)
                begin
                    state_next = ST_LOAD_CHECK;
                end
                else
                begin
                    rd_start_next = 1'b1;
                    state_next    = ST_LOAD_BYTE;
                end
            end

            ST_RUN:
            begin
                if (cpu_enable && i_cpu_end_program)
                begin
                    cpu_enable_next = 1'b0;
                    msg_next        = '{kind: MSG_INFO, code: `DBG_INFO_END_PROGRAM};
                    msg_valid_next  = 1'b1;
                    state_next      = ST_QUEUE;
                end
                else
                begin
                    cpu_enable_next = 1'b1;
                end
            end

            // held here while the response FIFO is full
            ST_QUEUE:
            begin
                if (i_msg_ready)
                begin
                    msg_valid_next = 1'b0;
                    state_next     = ST_IDLE;
                end
            end

            default:
            begin
                state_next = ST_IDLE;
            end
        endcase
    end

    // load bytes pass straight on so the word is written one cycle later
    assign o_byte_strobe       = (state == ST_LOAD_BYTE) && i_rd_end;
    assign o_byte              = i_rd_data;
    assign o_rd_start          = rd_start;
    assign o_asm_clear         = asm_clear;
    assign o_cpu_flush         = cpu_flush;
    assign o_cpu_clear_program = cpu_clear;
    assign o_cpu_enable        = cpu_enable;
    assign o_msg_valid         = msg_valid;
    assign o_msg               = msg;

endmodule

`default_nettype wire

// ==== rtl/instr_assembler.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dbg_cfg.svh"

module instr_assembler
    import dbg_data_pkg::*;
    import dbg_ctrl_pkg::*;
(
    input  wire logic        i_clk,
    input  wire logic        i_reset,
    input  wire logic        i_clear,
    input  wire logic        i_byte_strobe,
    input  wire uart_byte_t  i_byte,
    output imem_write_t      o_imem
);

    localparam int CNT_BITS   = $clog2(`DBG_BYTES_PER_INSTR);
    localparam int KEEP_BITS  = `DBG_INSTR_BITS - `DBG_BYTE_BITS;

    logic [CNT_BITS-1:0] byte_cnt;
    instr_t              shift_q;
    instr_t              shift_next;
    logic                last_byte;
    logic                wr_strobe;
    logic                wr_halt;
    instr_t              wr_instr;

    // first byte ends up in the top position
    assign shift_next = {shift_q[KEEP_BITS-1:0], i_byte};
    assign last_byte  = (byte_cnt == CNT_BITS'(`DBG_BYTES_PER_INSTR - 1));

    always_ff @(posedge i_clk)
    begin
        if (i_reset || i_clear)
        begin
            byte_cnt  <= '0;
            wr_strobe <= 1'b0;
        end
        else
        begin
            wr_strobe <= i_byte_strobe && last_byte;
            if (i_byte_strobe)
            begin
                byte_cnt <= last_byte ? '0 : byte_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (i_byte_strobe)
        begin
            shift_q <= shift_next;
            if (last_byte)
            begin
                wr_instr <= shift_next;
                wr_halt  <= (shift_next == `DBG_INSTR_HALT);
            end
        end
    end

    assign o_imem = '{strobe: wr_strobe, halt: wr_halt, instr: wr_instr};

endmodule

`default_nettype wire

// ==== rtl/dbg_ctrl_pkg.sv ====
`default_nettype none

package dbg_ctrl_pkg;

    import dbg_data_pkg::*;

    // command FSM states
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_WAIT_CMD,
        ST_LOAD_FLUSH,
        ST_LOAD_CHECK,
        ST_LOAD_BYTE,
        ST_LOAD_WAIT,
        ST_RUN,
        ST_QUEUE
    } ctrl_state_t;

    typedef enum logic {
        MSG_INFO  = 1'b0,
        MSG_ERROR = 1'b1
    } msg_kind_t;

    // one queued response, formatted later by the transmitter
    typedef struct packed {
        msg_kind_t kind;
        msg_code_t code;
    } resp_msg_t;

    // instruction memory write from the assembler
    typedef struct packed {
        logic   strobe;
        logic   halt;
        instr_t instr;
    } imem_write_t;

endpackage

`default_nettype wire

// ==== rtl/dbg_data_pkg.sv ====
`default_nettype none

`include "dbg_cfg.svh"

package dbg_data_pkg;

    // one byte from the uart receiver
    typedef logic [`DBG_BYTE_BITS-1:0] uart_byte_t;

    // one instruction word for the core
    typedef logic [`DBG_INSTR_BITS-1:0] instr_t;

    // word sent to the uart transmitter
    // prefix in the top byte, zero padding, code in the low byte
    typedef logic [`DBG_RESP_BITS-1:0] resp_word_t;

    // info or error code carried in a response
    typedef logic [`DBG_BYTE_BITS-1:0] msg_code_t;

endpackage

`default_nettype wire

// ==== rtl/dbg_cfg.svh ====
`ifndef DBG_CFG_SVH
`define DBG_CFG_SVH

// bus and word widths
`define DBG_BYTE_BITS        8
`define DBG_INSTR_BITS       32
`define DBG_BYTES_PER_INSTR  4
`define DBG_RESP_BITS        32

// response queue entries
`define DBG_FIFO_DEPTH       4

// last instruction of a program
`define DBG_INSTR_HALT       32'hFFFF_FFFF

// command characters, ascii
`define DBG_CMD_LOAD         8'h4C
`define DBG_CMD_FLUSH        8'h46
`define DBG_CMD_RUN          8'h45

// response prefixes, top byte of the word
`define DBG_PREFIX_INFO      8'h49
`define DBG_PREFIX_ERROR     8'h45

`define DBG_INFO_LOAD_DONE   8'h01
`define DBG_INFO_END_PROGRAM 8'h02
`define DBG_ERR_UNKNOWN_CMD  8'h01
`define DBG_ERR_IMEM_FULL    8'h02

`endif
